/* sim/bakeryStim.txt */
# Columns: test name, select, pause, number of steps, expected critical, expected holding
# Expected values are binary with the highest process on the left
soloEntry     1 0 24 010 010
soloPaused    1 1 10 010 010
soloExit      1 0  9 000 000
soloToIdle    1 0  1 000 000
p2Ticket      2 0 11 000 100
p0Ticket      0 0 11 000 101
p0Blocked     0 0 30 000 101
p2Enter       2 0 13 100 101
p2Exit        2 0 10 000 001
p0Enter       0 0  3 001 001
p0Exit        0 0 10 000 000
clampEntry    3 0 24 001 001
clampExit     3 0 10 000 000
pausedEntry   2 1 30 100 100
pausedExit    2 0  9 000 000
exitPause     2 1  5 000 000
exitRelease   2 0  1 000 000
reentry       2 0 24 100 100

/* bakeryTop.f */
logic/bakeryPkg.sv
logic/deferPort.sv
logic/stepScheduler.sv
logic/deferMatrix.sv
logic/stepEngine.sv
logic/bakeryTop.sv
sim/bakeryTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the bakery testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module bakeryTb -f bakeryTop.f

output=$(./obj_dir/VbakeryTb)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

/* sim/bakeryTb.sv */
/*
 * Testbench for bakeryTop with three processes, run from the project root.
 * Step groups come from sim/bakeryStim.txt. Each cycle executes a step.
 * A group's outputs are compared two clocks after its last step is driven.
 */
`timescale 1ns/10ps
`default_nettype none

module bakeryTb;
	localparam int numProcs = 3;
	localparam int maxGroups = 32;
	localparam int randSteps = 2000;

	logic clock;
	logic rst;
	logic [1:0] select;
	logic pause;
	logic [2:0] critical;
	logic [2:0] holding;

	// Step groups from the stimulus file
	logic [8*16-1:0] groupName [maxGroups];
	logic [1:0] groupSel [maxGroups];
	logic groupPause [maxGroups];
	int groupCount [maxGroups];
	logic [2:0] expCritical [maxGroups];
	logic [2:0] expHolding [maxGroups];
	int numGroups;

	// Checks waiting for their group to come out of the pipeline
	int dueCycle [$];
	int dueGroup [$];
	int cycle;
	int passCount;
	int failCount;
	int violations;
	// Random cycles with some process in the critical section
	int busyCycles;
	logic [31:0] lfsrState;

	bakeryTop #(.numProcs(numProcs)) i_dut (
		.clock    (clock),
		.rst      (rst),
		.select   (select),
		.pause    (pause),
		.critical (critical),
		.holding  (holding)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// Galois LFSR with feedback polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	function automatic logic randomBit();
		lfsrState = lfsrNext(lfsrState);
		return lfsrState[0];
	endfunction

	task automatic readStim();
		int fd;
		int got;
		logic [8*128-1:0] line;
		logic [8*16-1:0] name;
		logic [1:0] sel;
		logic pau;
		int cnt;
		logic [2:0] crit;
		logic [2:0] hold;
		numGroups = 0;
		fd = $fopen("sim/bakeryStim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file sim/bakeryStim.txt");
			failCount++;
		end else begin
			while ($fgets(line, fd) != 0 && numGroups < maxGroups) begin
				got = $sscanf(line, "%s %d %d %d %b %b", name, sel, pau, cnt, crit, hold);
				// Comment and blank lines give fewer fields
				if (got == 6) begin
					groupName[numGroups] = name;
					groupSel[numGroups] = sel;
					groupPause[numGroups] = pau;
					groupCount[numGroups] = cnt;
					expCritical[numGroups] = crit;
					expHolding[numGroups] = hold;
					numGroups++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkDue();
		int g;
		while (dueCycle.size() > 0 && dueCycle[0] == cycle) begin
			g = dueGroup[0];
			void'(dueCycle.pop_front());
			void'(dueGroup.pop_front());
			if (critical !== expCritical[g] || holding !== expHolding[g]) begin
				$display("error %0s: expected crit %b hold %b, actual crit %b hold %b",
					groupName[g], expCritical[g], expHolding[g], critical, holding);
				failCount++;
			end else begin
				$display("ok %0s", groupName[g]);
				passCount++;
			end
		end
	endtask

	// Drive one step now, then move to just after the next rising edge
	task automatic stepOnce(input logic [1:0] sel, input logic pau);
		checkDue();
		select = sel;
		pause = pau;
		@(posedge clock);
		#1;
		cycle++;
	endtask

	task automatic checkMutex();
		if ((critical & (critical - 3'd1)) != 3'd0) begin
			$display("more than one process in the critical section (%b) at cycle %0d",
				critical, cycle);
			violations++;
		end
		if ((critical & ~holding) != 3'd0) begin
			$display("critical %b without its ticket in holding %b at cycle %0d",
				critical, holding, cycle);
			violations++;
		end
	endtask

	initial begin
		int waited;
		logic [1:0] sel;
		logic pau;
		rst = 1'b1;
		select = '0;
		pause = 1'b0;
		cycle = 0;
		passCount = 0;
		failCount = 0;
		violations = 0;
		busyCycles = 0;
		lfsrState = 32'd90399;
		readStim();
		for (int i = 0; i < 8; i++) begin
			@(posedge clock);
		end
		#1;
		if (critical !== 3'b000 || holding !== 3'b000) begin
			$display("error reset: expected crit 000 hold 000, actual crit %b hold %b",
				critical, holding);
			failCount++;
		end else begin
			$display("ok reset");
			passCount++;
		end
		// First step goes in together with the reset release
		rst = 1'b0;
		for (int g = 0; g < numGroups; g++) begin
			for (int r = 0; r < groupCount[g]; r++) begin
				stepOnce(groupSel[g], groupPause[g]);
			end
			dueCycle.push_back(cycle + 1);
			dueGroup.push_back(g);
		end
		waited = 0;
		while (dueCycle.size() > 0 && waited < 4) begin
			stepOnce(2'd0, 1'b1);
			waited++;
		end
		if (dueCycle.size() > 0) begin
			$display("timeout: %0d group checks never came due", dueCycle.size());
			failCount++;
		end
		for (int s = 0; s < randSteps; s++) begin
			sel[1] = randomBit();
			sel[0] = randomBit();
			pau = randomBit();
			stepOnce(sel, pau);
			checkMutex();
			if (critical != 3'd0) begin
				busyCycles++;
			end
		end
		if (violations != 0) begin
			$display("mutex broken in %0d checks over %0d random steps", violations, randSteps);
			failCount++;
		end else if (busyCycles == 0) begin
			$display("no process reached the critical section in %0d random steps", randSteps);
			failCount++;
		end else begin
			$display("ok mutex");
			passCount++;
		end
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/bakeryTop.sv */
/*
 * Bakery mutual exclusion for numProcs processes.
 * One step per clock, and a step shows on the outputs two edges after it is driven.
 * A select at or above numProcs steps process 0.
 */
`timescale 1ns/10ps
`default_nettype none

module bakeryTop #(
	parameter int numProcs = bakeryPkg::defaultProcs
) (
	input  logic                               clock,
	input  logic                               rst,
	input  logic [$clog2(numProcs + 1) - 1:0] select,
	input  logic                               pause,
	output logic [numProcs - 1:0]              critical,
	output logic [numProcs - 1:0]              holding
);
	localparam int idxW = $clog2(numProcs + 1);

	logic stepValid;
	logic [idxW - 1:0] stepSel;
	logic stepPause;

	deferPort #(.numProcs(numProcs)) matrixPort ();

	stepScheduler #(.numProcs(numProcs)) i_stepScheduler (
		.clock     (clock),
		.rst       (rst),
		.select    (select),
		.pause     (pause),
		.stepValid (stepValid),
		.stepSel   (stepSel),
		.stepPause (stepPause)
	);

	stepEngine #(.numProcs(numProcs)) i_stepEngine (
		.clock     (clock),
		.rst       (rst),
		.stepValid (stepValid),
		.stepSel   (stepSel),
		.stepPause (stepPause),
		.port      (matrixPort.engine),
		.critical  (critical),
		.holding   (holding)
	);

	deferMatrix #(.numProcs(numProcs)) i_deferMatrix (
		.clock (clock),
		.rst   (rst),
		.port  (matrixPort.store)
	);

endmodule

`default_nettype wire

/* logic/stepEngine.sv */
/*
 * Second stage. Advances the selected process by one program step.
 * stepSel must already be below numProcs.
 * Matrix changes and all state updates happen at the same clock edge.
 */
`timescale 1ns/10ps
`default_nettype none

module stepEngine #(
	parameter int numProcs = bakeryPkg::defaultProcs
) (
	input  logic                               clock,
	input  logic                               rst,
	input  logic                               stepValid,
	input  logic [$clog2(numProcs + 1) - 1:0] stepSel,
	input  logic                               stepPause,
	deferPort.engine                           port,
	output logic [numProcs - 1:0]              critical,
	output logic [numProcs - 1:0]              holding
);
	localparam int idxW = $clog2(numProcs + 1);
	localparam logic [idxW - 1:0] lastIdx = idxW'(numProcs - 1);

	// Per-process state
	bakeryPkg::loc pc [numProcs];
	logic [idxW - 1:0] j [numProcs];
	logic [idxW - 1:0] pri [numProcs];
	logic [numProcs - 1:0] ticket;
	logic [numProcs - 1:0] choosing;

	bakeryPkg::loc curPc;
	bakeryPkg::loc nextPc;
	logic [idxW - 1:0] k;
	logic [idxW - 1:0] nextJ;
	logic [idxW - 1:0] selPri;
	logic [idxW - 1:0] kPri;
	logic [idxW - 1:0] priKVal;
	logic kInRange;
	logic kTicket;
	logic kChoosing;
	logic lend;
	logic blocked;
	logic ticketWr;
	logic ticketVal;
	logic choosingWr;
	logic choosingVal;
	logic priSelWr;
	logic priKWr;

	assign curPc = pc[stepSel];
	assign k = j[stepSel];
	assign selPri = pri[stepSel];

	// Process being visited by the loop index
	assign kInRange = (k <= lastIdx);
	assign kTicket = kInRange && ticket[k];
	assign kChoosing = kInRange && choosing[k];
	assign kPri = kInRange ? pri[k] : '0;

	// Older ticket, or same age with a better priority, holds us at L7
	assign blocked = kTicket && (port.rowBit || (!port.crossBit && (kPri < selPri)));
	// We defer to an older ticket that carries a worse priority
	assign lend = kTicket && port.rowBit && !port.crossBit && (selPri < kPri);

	assign port.row = stepSel;
	assign port.col = k;
	assign port.bitValue = kTicket;

	always_comb begin
		nextPc = curPc;
		nextJ = k;
		ticketWr = 1'b0;
		ticketVal = 1'b0;
		choosingWr = 1'b0;
		choosingVal = 1'b0;
		priSelWr = 1'b0;
		priKWr = 1'b0;
		priKVal = selPri;
		port.op = bakeryPkg::deferNone;
		case (curPc)
			bakeryPkg::L1: begin
				choosingWr = 1'b1;
				choosingVal = 1'b1;
				nextPc = bakeryPkg::L2a;
			end
			bakeryPkg::L2a: begin
				nextJ = '0;
				nextPc = bakeryPkg::L2b;
			end
			bakeryPkg::L2b: begin
				nextPc = kInRange ? bakeryPkg::L2c : bakeryPkg::L3;
			end
			bakeryPkg::L2c: begin
				port.op = bakeryPkg::deferRecord;
				nextJ = k + 1'b1;
				nextPc = bakeryPkg::L2b;
			end
			bakeryPkg::L3: begin
				ticketWr = 1'b1;
				ticketVal = 1'b1;
				choosingWr = 1'b1;
				nextPc = bakeryPkg::L4;
			end
			bakeryPkg::L4: begin
				nextJ = '0;
				priSelWr = 1'b1;
				nextPc = bakeryPkg::L5;
			end
			bakeryPkg::L5: begin
				nextPc = kInRange ? bakeryPkg::L6 : bakeryPkg::L9;
			end
			bakeryPkg::L6: begin
				nextPc = kChoosing ? bakeryPkg::L6 : bakeryPkg::L7;
			end
			bakeryPkg::L7: begin
				// Priority inheritance toward the older ticket
				priKWr = lend;
				nextPc = blocked ? bakeryPkg::L7 : bakeryPkg::L8;
			end
			bakeryPkg::L8: begin
				nextJ = k + 1'b1;
				priSelWr = 1'b1;
				nextPc = bakeryPkg::L5;
			end
			bakeryPkg::L9: begin
				nextPc = stepPause ? bakeryPkg::L9 : bakeryPkg::L10a;
			end
			bakeryPkg::L10a: begin
				ticketWr = 1'b1;
				nextJ = '0;
				nextPc = bakeryPkg::L10b;
			end
			bakeryPkg::L10b: begin
				nextPc = kInRange ? bakeryPkg::L10c : bakeryPkg::L11;
			end
			bakeryPkg::L10c: begin
				port.op = bakeryPkg::deferRelease;
				// Give back a priority we lent earlier
				priKWr = (kPri == stepSel);
				priKVal = k;
				nextJ = k + 1'b1;
				nextPc = bakeryPkg::L10b;
			end
			bakeryPkg::L11: begin
				nextPc = stepPause ? bakeryPkg::L11 : bakeryPkg::L1;
			end
			default: begin
				nextPc = bakeryPkg::L1;
			end
		endcase
		if (!stepValid) begin
			port.op = bakeryPkg::deferNone;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int p = 0; p < numProcs; p++) begin
				pc[p] <= bakeryPkg::L1;
				j[p] <= '0;
				pri[p] <= idxW'(p);
			end
			ticket <= '0;
			choosing <= '0;
			critical <= '0;
		end else if (stepValid) begin
			pc[stepSel] <= nextPc;
			j[stepSel] <= nextJ;
			critical[stepSel] <= (nextPc == bakeryPkg::L9);
			if (ticketWr) begin
				ticket[stepSel] <= ticketVal;
			end
			if (choosingWr) begin
				choosing[stepSel] <= choosingVal;
			end
			if (priSelWr) begin
				pri[stepSel] <= stepSel;
			end
			if (priKWr) begin
				pri[k] <= priKVal;
			end
		end
	end

	assign holding = ticket;

endmodule

`default_nettype wire

/* logic/deferMatrix.sv */
/*
 * numProcs by numProcs deference matrix. Bit [a][b] set means a defers to b.
 * Out-of-range row or column indices read as 0 and write nothing.
 * Writes land at the clock edge, and lookups are combinational.
 */
`timescale 1ns/10ps
`default_nettype none

module deferMatrix #(
	parameter int numProcs = bakeryPkg::defaultProcs
) (
	input  logic     clock,
	input  logic     rst,
	deferPort.store  port
);
	localparam int idxW = $clog2(numProcs + 1);
	localparam logic [idxW - 1:0] lastIdx = idxW'(numProcs - 1);

	logic [numProcs - 1:0] defer [numProcs];
	logic inRange;

	assign inRange = (port.row <= lastIdx) && (port.col <= lastIdx);

	// Forward and crossed lookups for the wait test
	always_comb begin
		port.rowBit = 1'b0;
		port.crossBit = 1'b0;
		if (inRange) begin
			port.rowBit = defer[port.row][port.col];
			port.crossBit = defer[port.col][port.row];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int r = 0; r < numProcs; r++) begin
				defer[r] <= '0;
			end
		end else if (inRange) begin
			case (port.op)
				bakeryPkg::deferRecord: begin
					// Ticket scan notes whether col holds a ticket
					defer[port.row][port.col] <= port.bitValue;
				end
				bakeryPkg::deferRelease: begin
					// Exit cleanup, so col no longer defers to row
					defer[port.col][port.row] <= 1'b0;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/stepScheduler.sv */
/*
 * First stage. Samples the host's process selection every clock.
 * A select above numProcs-1 is turned into process 0.
 * There is no back-pressure, so one step leaves every cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module stepScheduler #(
	parameter int numProcs = bakeryPkg::defaultProcs
) (
	input  logic                               clock,
	input  logic                               rst,
	input  logic [$clog2(numProcs + 1) - 1:0] select,
	input  logic                               pause,
	output logic                               stepValid,
	output logic [$clog2(numProcs + 1) - 1:0] stepSel,
	output logic                               stepPause
);
	localparam int idxW = $clog2(numProcs + 1);
	localparam logic [idxW - 1:0] lastIdx = idxW'(numProcs - 1);

	// Steps flow from the first cycle after reset
	always_ff @(posedge clock) begin
		if (rst) begin
			stepValid <= 1'b0;
		end else begin
			stepValid <= 1'b1;
		end
	end

	// Step payload
	always_ff @(posedge clock) begin
		if (select > lastIdx) begin
			stepSel <= '0;
		end else begin
			stepSel <= select;
		end
		stepPause <= pause;
	end

endmodule

`default_nettype wire

/* logic/deferPort.sv */
/*
 * Link from the step engine to the deference-matrix store.
 * An operation takes effect at the clock edge that ends its cycle.
 * Both lookups show the registered matrix only.
 */
`timescale 1ns/10ps
`default_nettype none

interface deferPort #(
	parameter int numProcs = bakeryPkg::defaultProcs
);
	localparam int idxW = $clog2(numProcs + 1);

	bakeryPkg::deferOp op;
	logic [idxW - 1:0] row;
	logic [idxW - 1:0] col;
	logic bitValue;
	// defer[row][col]
	logic rowBit;
	// defer[col][row]
	logic crossBit;

	modport engine (
		output op,
		output row,
		output col,
		output bitValue,
		input  rowBit,
		input  crossBit
	);

	modport store (
		input  op,
		input  row,
		input  col,
		input  bitValue,
		output rowBit,
		output crossBit
	);

endinterface

`default_nettype wire

/* logic/bakeryPkg.sv */
/*
 * Shared types for the bakery mutual-exclusion model.
 * The location enum is 4 bits and uses 15 of its 16 codes.
 */
`default_nettype none

package bakeryPkg;

	// Default number of competing processes
	localparam int defaultProcs = 3;

	// Program locations of one process
	typedef enum logic [3:0] {
		L1,
		L2a,
		L2b,
		L2c,
		L3,
		L4,
		L5,
		L6,
		L7,
		L8,
		// Critical section
		L9,
		L10a,
		L10b,
		L10c,
		// Exit point
		L11
	} loc;

	// Operations on the deference matrix
	typedef enum logic [1:0] {
		// Leave the matrix unchanged
		deferNone,
		// Write one bit of the stepping process's row
		deferRecord,
		// Clear the stepping process's bit in another row
		deferRelease
	} deferOp;

endpackage

`default_nettype wire
